//--- build.f
+incdir+source
source/rvPkg.sv
source/hazardUnit.sv
source/instrDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/instrMemory.sv
source/dataMemory.sv
source/rvCore.sv
dv/rvCoreAssertions.sv
dv/rvCoreTb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rvPkg.sv
      - source/hazardUnit.sv
      - source/instrDecoder.sv
      - source/registerFile.sv
      - source/aluUnit.sv
      - source/instrMemory.sv
      - source/dataMemory.sv
      - source/rvCore.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/rvCoreAssertions.sv
      - dv/rvCoreTb.sv

//--- dv/rvCoreTb.sv
`timescale 1ns/1ps
`include "rvSettings.svh"

module rvCoreTb;

    import rvPkg::*;

    localparam int imemAddrW = $clog2(`IMEM_WORDS);
    // ALU kinds used by the assembler
    localparam int addKind = 0;
    localparam int subKind = 1;
    localparam int andKind = 2;
    localparam int orKind = 3;
    localparam int sltKind = 4;

    logic clk;
    logic reset;
    logic imemLoadEnable;
    logic [imemAddrW-1:0] imemLoadAddr;
    wordT imemLoadData;
    logic retireValid;
    regAddrT retireRd;
    wordT retireData;
    logic storeValid;
    wordT storeAddr;
    wordT storeData;

    wordT prog [$];
    regAddrT expRetRd [$];
    wordT expRetData [$];
    wordT expStAddr [$];
    wordT expStData [$];
    string testName;
    int eventsSeen = 0;
    int eventsExpected = 0;
    int assertFailures = 0;
    time deadline = 0;

    rvCore i_rvCore (
        .clk(clk), .reset(reset), .imemLoadEnable(imemLoadEnable),
        .imemLoadAddr(imemLoadAddr), .imemLoadData(imemLoadData),
        .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    // Hazard checks see the testbench clock and reset through absolute names
    bind hazardUnit rvCoreAssertions i_rvCoreAssertions (
        .clk(rvCoreTb.clk), .reset(rvCoreTb.reset), .stall(stall), .flush(flush),
        .memReadE(memReadE), .rs1E(rs1E), .rs2E(rs2E), .forwardAE(forwardAE),
        .forwardBE(forwardBE)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic compareValue(input string what, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED %s: %s expected 0x%08h actual 0x%08h",
                               testName, what, expected, actual));
        end
    endtask

    function automatic wordT rTypeWord(input int kind, input regAddrT rd, input regAddrT rs1,
                                       input regAddrT rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = 7'b0000000;
        case (kind)
            addKind: f3 = 3'b000;
            subKind: begin
                f7 = 7'b0100000;
                f3 = 3'b000;
            end
            andKind: f3 = 3'b111;
            orKind: f3 = 3'b110;
            default: f3 = 3'b010;
        endcase
        return {f7, rs2, rs1, f3, rd, opRType};
    endfunction

    function automatic wordT addiWord(input regAddrT rd, input regAddrT rs1, input int imm);
        return {imm[11:0], rs1, 3'b000, rd, opIType};
    endfunction

    function automatic wordT lwWord(input regAddrT rd, input regAddrT rs1, input int imm);
        return {imm[11:0], rs1, 3'b010, rd, opLoad};
    endfunction

    function automatic wordT swWord(input regAddrT rs2, input regAddrT rs1, input int imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    // Offset is in bytes relative to the branch itself
    function automatic wordT beqWord(input regAddrT rs1, input regAddrT rs2, input int off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], opBranch};
    endfunction

    // ISA-level model that runs the program in order and lists the visible register writes
    // and stores until it reaches the BEQ x0,x0 self-loop
    function automatic void runReference();
        wordT regs [32];
        wordT mem [`DMEM_WORDS];
        wordT ins, a, b, res, addr;
        wordT immI, immS, immB;
        regAddrT rd;
        int pcIdx;
        bit writes;
        bit done;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
        expRetRd.delete();
        expRetData.delete();
        expStAddr.delete();
        expStData.delete();
        pcIdx = 0;
        done = 1'b0;
        for (int step = 0; step < 4 * `IMEM_WORDS && !done; step++) begin
            ins = prog[pcIdx];
            rd = ins[11:7];
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            res = '0;
            writes = 1'b0;
            pcIdx++;
            case (ins[6:0])
                opRType: begin
                    writes = 1'b1;
                    case ({ins[30], ins[14:12]})
                        4'b0_000: res = a + b;
                        4'b1_000: res = a - b;
                        4'b0_111: res = a & b;
                        4'b0_110: res = a | b;
                        default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                end
                opIType: begin
                    writes = 1'b1;
                    res = a + immI;
                end
                opLoad: begin
                    writes = 1'b1;
                    addr = a + immI;
                    res = mem[(addr >> 2) % `DMEM_WORDS];
                end
                opStore: begin
                    addr = a + immS;
                    mem[(addr >> 2) % `DMEM_WORDS] = b;
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                end
                opBranch: begin
                    if (a == b && immB == '0) begin
                        done = 1'b1;
                    end else if (a == b) begin
                        pcIdx = pcIdx - 1 + int'($signed(immB)) / 4;
                    end
                end
                default: ;
            endcase
            // x0 stays zero and its writes are invisible
            if (writes && rd != '0) begin
                regs[rd] = res;
                expRetRd.push_back(rd);
                expRetData.push_back(res);
            end
            if (pcIdx >= prog.size()) done = 1'b1;
        end
    endfunction

    // Sixty random instructions over x0..x7 with forward branches and eight data words
    task automatic buildRandomProgram();
        int kind;
        int span;
        regAddrT rd, rs1, rs2;
        prog.delete();
        for (int i = 0; i < 60; i++) begin
            kind = $urandom_range(0, 9);
            rd = regAddrT'($urandom_range(0, 7));
            rs1 = regAddrT'($urandom_range(0, 7));
            rs2 = regAddrT'($urandom_range(0, 7));
            span = (60 - i < 6) ? 60 - i : 6;
            case (kind)
                0, 1, 2, 3: prog.push_back(rTypeWord($urandom_range(0, 4), rd, rs1, rs2));
                6: prog.push_back(lwWord(rd, 0, 4 * $urandom_range(0, 7)));
                7: prog.push_back(swWord(rs2, 0, 4 * $urandom_range(0, 7)));
                8: prog.push_back(beqWord(rs1, rs2, 4 * $urandom_range(1, span)));
                default: prog.push_back(addiWord(rd, rs1, int'($urandom_range(0, 63)) - 32));
            endcase
        end
        prog.push_back(beqWord(0, 0, 0));
    endtask

    // Holds reset, loads the program one word per cycle and waits for every expected event
    task automatic runTest(input string name);
        deadline = $time + (41 * prog.size() + 150) * 20;
        @(posedge clk);
        reset <= 1'b1;
        imemLoadEnable <= 1'b0;
        repeat (2) @(posedge clk);
        testName = name;
        runReference();
        eventsExpected += expRetRd.size() + expStAddr.size();
        foreach (prog[i]) begin
            imemLoadEnable <= 1'b1;
            imemLoadAddr <= imemAddrW'(i);
            imemLoadData <= prog[i];
            @(posedge clk);
        end
        imemLoadEnable <= 1'b0;
        reset <= 1'b0;
        while (expRetRd.size() != 0 || expStAddr.size() != 0) @(posedge clk);
        // A few more cycles catch any event past the end of the list
        repeat (10) @(posedge clk);
    endtask

    // Outputs are sampled at the edge, before the pipeline moves on
    always @(posedge clk) begin : compareEvents
        regAddrT expRd;
        wordT expValue;
        wordT expAddr;
        if (!reset && retireValid) begin
            if (expRetRd.size() == 0) begin
                abortRun($sformatf("Test %s retired a write to x%0d that the model never made",
                                   testName, retireRd));
            end else begin
                expRd = expRetRd.pop_front();
                expValue = expRetData.pop_front();
                compareValue("retire rd", wordT'(expRd), wordT'(retireRd));
                compareValue($sformatf("retire data of x%0d", expRd), expValue, retireData);
                eventsSeen++;
            end
        end
        if (!reset && storeValid) begin
            if (expStAddr.size() == 0) begin
                abortRun($sformatf("Test %s made a store to 0x%08h that the model never made",
                                   testName, storeAddr));
            end else begin
                expAddr = expStAddr.pop_front();
                expValue = expStData.pop_front();
                compareValue("store address", expAddr, storeAddr);
                compareValue("store data", expValue, storeData);
                eventsSeen++;
            end
        end
    end

    always @(posedge clk) begin
        if (assertFailures != 0) begin
            abortRun("A concurrent assertion on the hazard unit failed");
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if ($time > deadline) begin
                abortRun($sformatf("Test %s timed out waiting for its events", testName));
            end
        end
    end

    initial begin
        reset = 1'b1;
        imemLoadEnable = 1'b0;
        imemLoadAddr = '0;
        imemLoadData = '0;
        void'($urandom(32));

        // Back-to-back ALU dependencies with the memory stage ahead of writeback
        prog.delete();
        prog.push_back(addiWord(1, 0, 5));
        prog.push_back(addiWord(2, 0, 7));
        prog.push_back(rTypeWord(addKind, 3, 1, 2));
        prog.push_back(rTypeWord(addKind, 4, 3, 3));
        prog.push_back(addiWord(5, 0, 1));
        prog.push_back(addiWord(5, 5, 2));
        prog.push_back(rTypeWord(addKind, 6, 5, 5));
        prog.push_back(rTypeWord(andKind, 8, 3, 2));
        prog.push_back(rTypeWord(orKind, 9, 3, 1));
        prog.push_back(rTypeWord(subKind, 11, 0, 1));
        prog.push_back(rTypeWord(sltKind, 12, 11, 1));
        prog.push_back(rTypeWord(sltKind, 13, 1, 11));
        prog.push_back(beqWord(0, 0, 0));
        runTest("forwarding");

        // Load followed at once by its consumer
        prog.delete();
        prog.push_back(addiWord(1, 0, 42));
        prog.push_back(swWord(1, 0, 8));
        prog.push_back(lwWord(2, 0, 8));
        prog.push_back(rTypeWord(addKind, 3, 2, 2));
        prog.push_back(lwWord(4, 0, 8));
        prog.push_back(rTypeWord(subKind, 5, 1, 4));
        prog.push_back(beqWord(0, 0, 0));
        runTest("loadUse");

        // Store data straight from an ALU result and from a load
        prog.delete();
        prog.push_back(addiWord(1, 0, 16));
        prog.push_back(addiWord(2, 0, 99));
        prog.push_back(swWord(2, 1, 4));
        prog.push_back(lwWord(3, 0, 20));
        prog.push_back(swWord(3, 0, 24));
        prog.push_back(lwWord(4, 1, 8));
        prog.push_back(addiWord(6, 0, -3));
        prog.push_back(swWord(4, 0, 28));
        prog.push_back(beqWord(0, 0, 0));
        runTest("storeData");

        // A taken BEQ drops its two followers while a not-taken one falls through
        prog.delete();
        prog.push_back(addiWord(1, 0, 3));
        prog.push_back(addiWord(2, 0, 3));
        prog.push_back(beqWord(1, 2, 12));
        prog.push_back(addiWord(3, 0, 111));
        prog.push_back(swWord(1, 0, 0));
        prog.push_back(addiWord(4, 0, 4));
        prog.push_back(beqWord(1, 0, 8));
        prog.push_back(addiWord(5, 0, 5));
        prog.push_back(swWord(5, 0, 4));
        prog.push_back(beqWord(0, 0, 0));
        runTest("branches");

        // x0 writes stay hidden and x0 reads give zero
        prog.delete();
        prog.push_back(addiWord(0, 0, 9));
        prog.push_back(rTypeWord(addKind, 1, 0, 0));
        prog.push_back(addiWord(2, 0, 1));
        prog.push_back(rTypeWord(orKind, 0, 2, 2));
        prog.push_back(rTypeWord(addKind, 3, 0, 2));
        prog.push_back(lwWord(0, 0, 0));
        prog.push_back(swWord(0, 0, 4));
        prog.push_back(beqWord(0, 0, 0));
        runTest("zeroRegister");

        for (int t = 0; t < 20; t++) begin
            buildRandomProgram();
            runTest($sformatf("random%0d", t));
        end

        if (eventsSeen == eventsExpected) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abortRun($sformatf("Saw %0d events but the model expected %0d",
                               eventsSeen, eventsExpected));
        end
    end

endmodule

//--- dv/rvCoreAssertions.sv
`timescale 1ns/1ps

module rvCoreAssertions (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input logic memReadE,
    input rvPkg::regAddrT rs1E,
    input rvPkg::regAddrT rs2E,
    input rvPkg::forwardSelT forwardAE,
    input rvPkg::forwardSelT forwardBE
);

    import rvPkg::*;

    // A load-use stall always turns the execute entry into a bubble
    flushOnStall: assert property (@(posedge clk) disable iff (reset) stall |-> flush)
        else begin
            $error("stall is high while flush is low");
            rvCoreTb.assertFailures = rvCoreTb.assertFailures + 1;
        end

    // Only a load sitting in execute can hold the front of the pipeline
    stallNeedsLoad: assert property (@(posedge clk) disable iff (reset) stall |-> memReadE)
        else begin
            $error("stall is high without a load in execute");
            rvCoreTb.assertFailures = rvCoreTb.assertFailures + 1;
        end

    // x0 is constant zero, so it is never taken from a later stage
    noForwardOfX0A: assert property (@(posedge clk) disable iff (reset)
        (rs1E == '0) |-> (forwardAE == fwdNone))
        else begin
            $error("forwardAE is active for source register x0");
            rvCoreTb.assertFailures = rvCoreTb.assertFailures + 1;
        end

    noForwardOfX0B: assert property (@(posedge clk) disable iff (reset)
        (rs2E == '0) |-> (forwardBE == fwdNone))
        else begin
            $error("forwardBE is active for source register x0");
            rvCoreTb.assertFailures = rvCoreTb.assertFailures + 1;
        end

    // Pipeline valid bits are clear right after reset, so nothing can stall yet
    quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !stall)
        else begin
            $error("stall is high in the first cycle after reset");
            rvCoreTb.assertFailures = rvCoreTb.assertFailures + 1;
        end

endmodule

//--- source/rvCore.sv
`timescale 1ns/1ps
`include "rvSettings.svh"

module rvCore (
    input logic clk,
    input logic reset,
    input logic imemLoadEnable,
    input logic [$clog2(`IMEM_WORDS)-1:0] imemLoadAddr,
    input rvPkg::wordT imemLoadData,
    output logic retireValid,
    output rvPkg::regAddrT retireRd,
    output rvPkg::wordT retireData,
    output logic storeValid,
    output rvPkg::wordT storeAddr,
    output rvPkg::wordT storeData
);

    import rvPkg::*;

    // Fetch stage and IF/ID register
    wordT pc, fetchInstr, instrD, pcD;
    logic validD;
    // Decode outputs
    regAddrT rs1D, rs2D, rdD;
    wordT immD, rdata1D, rdata2D;
    aluOpT aluOpD;
    logic aluSrcD, regWriteD, memReadD, memWriteD, branchD;
    // ID/EX register
    logic validE, aluSrcE, regWriteE, memReadE, memWriteE, branchE;
    wordT pcE, immE, rdata1E, rdata2E;
    regAddrT rs1E, rs2E, rdE;
    aluOpT aluOpE;
    // Execute stage
    forwardSelT forwardAE, forwardBE;
    wordT srcAE, srcBE, aluBE, aluResultE;
    logic equalE, flushBranch, stall, flush;
    // EX/MEM register
    logic validM, regWriteM, memReadM, memWriteM;
    regAddrT rdM;
    wordT aluResultM, writeDataM, readDataM;
    // MEM/WB register
    logic validW, regWriteW, memReadW;
    regAddrT rdW;
    wordT aluResultW, readDataW, resultW;

    // Picks an execute operand from the register file or a younger pipeline stage
    function automatic wordT forwardMux(input forwardSelT sel, input wordT regValue,
                                        input wordT wbValue, input wordT memAlu,
                                        input wordT memLoad);
        case (sel)
            fwdWriteback: return wbValue;
            fwdMemAlu: return memAlu;
            fwdMemLoad: return memLoad;
            default: return regValue;
        endcase
    endfunction

    // Program load is only accepted while the core is held in reset
    instrMemory i_instrMemory (
        .clk(clk), .loadEnable(imemLoadEnable && reset), .loadAddr(imemLoadAddr),
        .loadData(imemLoadData), .fetchAddr(pc), .fetchInstr(fetchInstr)
    );

    // A taken branch redirects fetch, a stall freezes it
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (flushBranch) begin
            pc <= pcE + immE;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushBranch) begin
            validD <= 1'b0;
        end else if (!stall) begin
            validD <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instrD <= fetchInstr;
            pcD <= pc;
        end
    end

    instrDecoder i_instrDecoder (
        .instr(instrD), .rs1(rs1D), .rs2(rs2D), .rd(rdD), .imm(immD), .aluOp(aluOpD),
        .aluSrc(aluSrcD), .regWrite(regWriteD), .memRead(memReadD), .memWrite(memWriteD),
        .branch(branchD)
    );

    registerFile i_registerFile (
        .clk(clk), .reset(reset), .rs1(rs1D), .rs2(rs2D), .rd(rdW),
        .writeEnable(validW && regWriteW), .writeData(resultW),
        .rdata1(rdata1D), .rdata2(rdata2D)
    );

    // Control bits of the execute entry, cleared to form a bubble
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            validE <= 1'b0;
            regWriteE <= 1'b0;
            memReadE <= 1'b0;
            memWriteE <= 1'b0;
            branchE <= 1'b0;
        end else begin
            validE <= validD;
            regWriteE <= regWriteD && validD;
            memReadE <= memReadD && validD;
            memWriteE <= memWriteD && validD;
            branchE <= branchD && validD;
        end
    end

    always_ff @(posedge clk) begin
        pcE <= pcD;
        immE <= immD;
        rdata1E <= rdata1D;
        rdata2E <= rdata2D;
        rs1E <= rs1D;
        rs2E <= rs2D;
        rdE <= rdD;
        aluOpE <= aluOpD;
        aluSrcE <= aluSrcD;
    end

    hazardUnit i_hazardUnit (
        .rdM(rdM), .rdW(rdW), .rdE(rdE), .rs1E(rs1E), .rs2E(rs2E), .rs1D(rs1D), .rs2D(rs2D),
        .regWriteM(regWriteM), .regWriteW(regWriteW), .memReadE(memReadE),
        .memReadM(memReadM), .flushBranch(flushBranch), .forwardAE(forwardAE),
        .forwardBE(forwardBE), .stall(stall), .flush(flush)
    );

    assign srcAE = forwardMux(forwardAE, rdata1E, resultW, aluResultM, readDataM);
    // srcBE is also the store data, taken before the immediate select
    assign srcBE = forwardMux(forwardBE, rdata2E, resultW, aluResultM, readDataM);
    assign aluBE = aluSrcE ? immE : srcBE;

    aluUnit i_aluUnit (
        .a(srcAE), .b(aluBE), .aluOp(aluOpE), .result(aluResultE), .equal(equalE)
    );

    // Branches are predicted not taken, so only an equal BEQ redirects
    assign flushBranch = validE && branchE && equalE;

    always_ff @(posedge clk) begin
        if (reset) begin
            validM <= 1'b0;
            regWriteM <= 1'b0;
            memReadM <= 1'b0;
            memWriteM <= 1'b0;
        end else begin
            validM <= validE;
            regWriteM <= regWriteE;
            memReadM <= memReadE;
            memWriteM <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        rdM <= rdE;
        aluResultM <= aluResultE;
        writeDataM <= srcBE;
    end

    dataMemory i_dataMemory (
        .clk(clk), .reset(reset), .addr(aluResultM), .writeEnable(validM && memWriteM),
        .writeData(writeDataM), .readData(readDataM)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            validW <= 1'b0;
            regWriteW <= 1'b0;
            memReadW <= 1'b0;
        end else begin
            validW <= validM;
            regWriteW <= regWriteM;
            memReadW <= memReadM;
        end
    end

    always_ff @(posedge clk) begin
        rdW <= rdM;
        aluResultW <= aluResultM;
        readDataW <= readDataM;
    end

    assign resultW = memReadW ? readDataW : aluResultW;

    // Writes to x0 are architecturally invisible and are not reported
    assign retireValid = validW && regWriteW && (rdW != '0);
    assign retireRd = rdW;
    assign retireData = resultW;

    assign storeValid = validM && memWriteM;
    assign storeAddr = aluResultM;
    assign storeData = writeDataM;

endmodule

//--- source/dataMemory.sv
`timescale 1ns/1ps
`include "rvSettings.svh"

module dataMemory (
    input logic clk,
    input logic reset,
    input rvPkg::wordT addr,
    input logic writeEnable,
    input rvPkg::wordT writeData,
    output rvPkg::wordT readData
);

    import rvPkg::*;

    localparam int addrW = $clog2(`DMEM_WORDS);

    wordT mem [`DMEM_WORDS];
    logic [addrW-1:0] wordIndex;

    // Only word accesses exist, so the two low byte bits are ignored
    assign wordIndex = addr[addrW+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEnable) begin
            mem[wordIndex] <= writeData;
        end
    end

    // Combinational read gives the load its data inside the memory stage
    assign readData = mem[wordIndex];

endmodule

//--- source/instrMemory.sv
`timescale 1ns/1ps
`include "rvSettings.svh"

module instrMemory (
    input logic clk,
    input logic loadEnable,
    input logic [$clog2(`IMEM_WORDS)-1:0] loadAddr,
    input rvPkg::wordT loadData,
    input rvPkg::wordT fetchAddr,
    output rvPkg::wordT fetchInstr
);

    import rvPkg::*;

    localparam int addrW = $clog2(`IMEM_WORDS);
    // ADDI x0, x0, 0 is the canonical NOP
    localparam wordT nopInstr = wordT'(opIType);

    wordT mem [`IMEM_WORDS];

    // Words never written by the load port hold a NOP
    initial begin
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            mem[i] = nopInstr;
        end
    end

    always @(posedge clk) begin
        if (loadEnable) begin
            mem[loadAddr] <= loadData;
        end
    end

    // The PC is a byte address, fetch drops the two offset bits
    assign fetchInstr = mem[fetchAddr[addrW+1:2]];

endmodule

//--- source/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input rvPkg::wordT a,
    input rvPkg::wordT b,
    input rvPkg::aluOpT aluOp,
    output rvPkg::wordT result,
    output logic equal
);

    import rvPkg::*;

    logic lessThan;

    // SLT compares the operands as two's complement numbers
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluSlt: result = wordT'(lessThan);
            default: result = '0;
        endcase
    end

    // BEQ resolves from this compare in execute
    assign equal = (a == b);

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ps
`include "rvSettings.svh"

module registerFile (
    input logic clk,
    input logic reset,
    input rvPkg::regAddrT rs1,
    input rvPkg::regAddrT rs2,
    input rvPkg::regAddrT rd,
    input logic writeEnable,
    input rvPkg::wordT writeData,
    output rvPkg::wordT rdata1,
    output rvPkg::wordT rdata2
);

    import rvPkg::*;

    // x0 has no storage, only registers 1 and up are kept
    wordT regs [1:(1 << `REG_ADDR_W) - 1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < (1 << `REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (rd != '0)) begin
            regs[rd] <= writeData;
        end
    end

    // Writeback and decode share a cycle, so a matching write is passed straight through
    assign rdata1 = (rs1 == '0) ? '0 :
                    (writeEnable && (rd == rs1)) ? writeData : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 :
                    (writeEnable && (rd == rs2)) ? writeData : regs[rs2];

endmodule

//--- source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input rvPkg::wordT instr,
    output rvPkg::regAddrT rs1,
    output rvPkg::regAddrT rs2,
    output rvPkg::regAddrT rd,
    output rvPkg::wordT imm,
    output rvPkg::aluOpT aluOp,
    output logic aluSrc,
    output logic regWrite,
    output logic memRead,
    output logic memWrite,
    output logic branch
);

    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    wordT immI;
    wordT immS;
    wordT immB;
    logic rTypeOk;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediates for the three formats in use
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // Branch offsets are in halfwords, so bit 0 is always zero
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        // Default is a no-op, which also covers every unsupported encoding
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        imm = '0;
        aluOp = aluAdd;
        aluSrc = 1'b0;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        branch = 1'b0;
        rTypeOk = 1'b0;

        case (opcode)
            opRType: begin
                rTypeOk = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: aluOp = aluAdd;
                    10'b0100000_000: aluOp = aluSub;
                    10'b0000000_111: aluOp = aluAnd;
                    10'b0000000_110: aluOp = aluOr;
                    10'b0000000_010: aluOp = aluSlt;
                    default: rTypeOk = 1'b0;
                endcase
                if (rTypeOk) begin
                    rs1 = instr[19:15];
                    rs2 = instr[24:20];
                    rd = instr[11:7];
                    regWrite = 1'b1;
                end
            end
            opIType: begin
                // ADDI is the only immediate ALU operation supported
                if (funct3 == 3'b000) begin
                    rs1 = instr[19:15];
                    rd = instr[11:7];
                    imm = immI;
                    aluSrc = 1'b1;
                    regWrite = 1'b1;
                end
            end
            opLoad: begin
                if (funct3 == 3'b010) begin
                    rs1 = instr[19:15];
                    rd = instr[11:7];
                    imm = immI;
                    aluSrc = 1'b1;
                    regWrite = 1'b1;
                    memRead = 1'b1;
                end
            end
            opStore: begin
                // rs2 carries the store data, the ALU adds base and offset
                if (funct3 == 3'b010) begin
                    rs1 = instr[19:15];
                    rs2 = instr[24:20];
                    imm = immS;
                    aluSrc = 1'b1;
                    memWrite = 1'b1;
                end
            end
            opBranch: begin
                if (funct3 == 3'b000) begin
                    rs1 = instr[19:15];
                    rs2 = instr[24:20];
                    imm = immB;
                    aluOp = aluSub;
                    branch = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input rvPkg::regAddrT rdM,
    input rvPkg::regAddrT rdW,
    input rvPkg::regAddrT rdE,
    input rvPkg::regAddrT rs1E,
    input rvPkg::regAddrT rs2E,
    input rvPkg::regAddrT rs1D,
    input rvPkg::regAddrT rs2D,
    input logic regWriteM,
    input logic regWriteW,
    input logic memReadE,
    input logic memReadM,
    input logic flushBranch,
    output rvPkg::forwardSelT forwardAE,
    output rvPkg::forwardSelT forwardBE,
    output logic stall,
    output logic flush
);

    import rvPkg::*;

    always_comb begin
        forwardAE = fwdNone;
        forwardBE = fwdNone;

        // First operand takes the youngest producer, so the memory stage wins over writeback
        // x0 is never forwarded since its value is always zero
        if (regWriteM && (rs1E == rdM) && (rs1E != '0)) begin
            forwardAE = fwdMemAlu;
        end else if (regWriteW && (rs1E == rdW) && (rs1E != '0)) begin
            forwardAE = fwdWriteback;
        end

        // Second operand also carries store data, so it may need the load result itself
        if (memReadM && (rs2E == rdM) && (rs2E != '0)) begin
            forwardBE = fwdMemLoad;
        end else if (regWriteM && (rs2E == rdM) && (rs2E != '0)) begin
            forwardBE = fwdMemAlu;
        end else if (regWriteW && (rs2E == rdW) && (rs2E != '0)) begin
            forwardBE = fwdWriteback;
        end

        // A load in execute has no data yet for the instruction right behind it
        stall = memReadE && ((rdE == rs1D) || (rdE == rs2D));

        // The execute entry becomes a bubble on a load-use stall or a taken branch
        flush = stall || flushBranch;
    end

endmodule

//--- source/rvPkg.sv
`include "rvSettings.svh"

package rvPkg;

    // One data or instruction word
    typedef logic [`XLEN-1:0] wordT;

    // Index into the architectural register file
    typedef logic [`REG_ADDR_W-1:0] regAddrT;

    // Source select for an execute-stage operand
    typedef logic [1:0] forwardSelT;

    // Register file value, no forwarding
    localparam forwardSelT fwdNone = 2'b00;
    // Result of the instruction in writeback
    localparam forwardSelT fwdWriteback = 2'b01;
    // ALU result of the instruction in the memory stage
    localparam forwardSelT fwdMemAlu = 2'b10;
    // Load data read by the instruction in the memory stage
    localparam forwardSelT fwdMemLoad = 2'b11;

    // Operations the ALU can perform for the supported subset
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // Major opcodes of the supported instruction formats
    localparam logic [6:0] opRType = 7'b0110011;
    localparam logic [6:0] opIType = 7'b0010011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

endpackage

//--- source/rvSettings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Width of a data word and of an instruction word
`define XLEN 32

// RV32I has 32 architectural registers, so five index bits
`define REG_ADDR_W 5

// Instruction memory depth in 32-bit words
`define IMEM_WORDS 256

// Data memory depth in 32-bit words
`define DMEM_WORDS 64

// Byte address of the first instruction fetched after reset
`define RESET_PC 32'h0000_0000

`endif
